// File: source/mul_pkg.sv
// Multiply datapath types shared by the subword multiplier, writeback register and top level
package mul_pkg;

  // Datapath widths
  localparam int unsigned WORD_W = 32;
  // Half operand plus one sign bit
  localparam int unsigned HALF_W = 17;
  // Destination register field in the writeback entry
  localparam int unsigned RD_W   = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [HALF_W-1:0] half_t;

  //////////////////////////////
  // Operator and sequence
  //////////////////////////////
  // Low word in one pass, or high word over four steps
  typedef enum logic {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_opcode_e;

  // Partial product currently in the multiplier
  typedef enum logic [1:0] {
    ALBL = 2'd0,
    ALBH = 2'd1,
    AHBL = 2'd2,
    AHBH = 2'd3
  } mult_state_e;

  // Entry handed to the register file write port
  typedef struct packed {
    logic [RD_W-1:0] rd;
    word_t           data;
  } wb_data_t;

endpackage

// File: source/instr_pkg.sv
// RV32 instruction encoding constants and the decoded multiply request used by decoder and multiplier
package instr_pkg;

  // Raw instruction and register address widths
  localparam int unsigned INSTR_W    = 32;
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [INSTR_W-1:0]    instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Major opcode and funct7
  //////////////////////////////
  // Register-register ALU group
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  // M extension marker in funct7
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Multiply funct3 codes, division codes sit at 3'b100 and up
  localparam logic [2:0] FUNCT3_MUL    = 3'b000;
  localparam logic [2:0] FUNCT3_MULH   = 3'b001;
  localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
  localparam logic [2:0] FUNCT3_MULHU  = 3'b011;

  //////////////////////////////
  // Decoded request
  //////////////////////////////
  // short_signed bit 0 marks rs1 signed, bit 1 marks rs2 signed
  typedef struct packed {
    logic                 en;
    mul_pkg::mul_opcode_e op;
    logic [1:0]           short_signed;
    reg_addr_t            rd;
  } mul_req_t;

endpackage

// File: source/mul_decoder.sv
// Combinational decode of an RV32M multiply instruction into a request for the multiplier
`timescale 1ns/10ps

module mul_decoder (
  input  logic                valid_i,
  input  instr_pkg::instr_t   instr_i,
  output instr_pkg::mul_req_t req_o,
  output logic                illegal_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       is_mul;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    is_mul             = 1'b0;
    req_o.op           = mul_pkg::MUL_M32;
    req_o.short_signed = 2'b00;
    req_o.rd           = instr_i[11:7];

    // Only the OP group with the M extension funct7 qualifies
    if ((opcode == instr_pkg::OPCODE_OP) && (funct7 == instr_pkg::FUNCT7_MULDIV)) begin
      case (funct3)
        instr_pkg::FUNCT3_MUL: begin
          // Low word is sign independent
          is_mul             = 1'b1;
          req_o.op           = mul_pkg::MUL_M32;
          req_o.short_signed = 2'b11;
        end
        instr_pkg::FUNCT3_MULH: begin
          is_mul             = 1'b1;
          req_o.op           = mul_pkg::MUL_H;
          req_o.short_signed = 2'b11;
        end
        instr_pkg::FUNCT3_MULHSU: begin
          // rs1 signed, rs2 unsigned
          is_mul             = 1'b1;
          req_o.op           = mul_pkg::MUL_H;
          req_o.short_signed = 2'b01;
        end
        instr_pkg::FUNCT3_MULHU: begin
          is_mul             = 1'b1;
          req_o.op           = mul_pkg::MUL_H;
          req_o.short_signed = 2'b00;
        end
        // DIV, DIVU, REM, REMU fall through as not a multiply
        default: ;
      endcase
    end

    req_o.en = valid_i && is_mul;
  end

  // Anything presented that is not a multiply
  assign illegal_o = valid_i && !is_mul;

endmodule

// File: source/mul_unit.sv
// Subword multiplier producing the low word in one cycle or the high word over four partial products
`timescale 1ns/10ps

module mul_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  instr_pkg::mul_req_t req_i,
  input  mul_pkg::word_t      op_a_i,
  input  mul_pkg::word_t      op_b_i,
  input  logic                ex_ready_i,
  output mul_pkg::word_t      product_o,
  output logic                done_o,
  output logic                busy_o
);

  // Sequence control
  logic                 is_m32;
  logic                 mulh_start;
  logic                 mulh_shift;
  logic                 mulh_save;
  logic                 acc_load;
  logic                 acc_clear;
  mul_pkg::mult_state_e state_q;
  mul_pkg::mult_state_e state_d;

  // Operand halves, upper ones carry the sign when asked
  mul_pkg::half_t       al;
  mul_pkg::half_t       bl;
  mul_pkg::half_t       ah;
  mul_pkg::half_t       bh;
  mul_pkg::half_t       mulh_a;
  mul_pkg::half_t       mulh_b;

  // Running accumulator with its saved carry
  mul_pkg::word_t       acc_q;
  logic                 carry_q;

  // Multiplier inputs and intermediate sums
  mul_pkg::word_t       op_a;
  mul_pkg::word_t       op_b;
  logic signed [33:0]   int_result;
  logic signed [32:0]   acc_ext;
  logic signed [33:0]   mulh_sum;
  logic signed [33:0]   mulh_result;

  assign is_m32     = (req_i.op == mul_pkg::MUL_M32);
  assign mulh_start = req_i.en && (req_i.op == mul_pkg::MUL_H);

  //////////////////////////////
  // Operand split
  //////////////////////////////
  assign al = {1'b0, op_a_i[15:0]};
  assign bl = {1'b0, op_b_i[15:0]};
  assign ah = {req_i.short_signed[0] && op_a_i[31], op_a_i[31:16]};
  assign bh = {req_i.short_signed[1] && op_b_i[31], op_b_i[31:16]};

  // Step through the four partial products
  always_comb begin
    state_d    = state_q;
    mulh_a     = al;
    mulh_b     = bl;
    mulh_shift = 1'b0;
    mulh_save  = 1'b0;
    acc_load   = 1'b0;
    acc_clear  = 1'b0;
    busy_o     = 1'b0;

    case (state_q)
      mul_pkg::ALBL: begin
        // Low part only contributes its upper 16 bits
        mulh_shift = 1'b1;
        if (mulh_start) begin
          busy_o   = 1'b1;
          acc_load = 1'b1;
          state_d  = mul_pkg::ALBH;
        end
      end
      mul_pkg::ALBH: begin
        // Cross term may overflow into bit 32
        mulh_b    = bh;
        mulh_save = 1'b1;
        acc_load  = 1'b1;
        busy_o    = 1'b1;
        state_d   = mul_pkg::AHBL;
      end
      mul_pkg::AHBL: begin
        mulh_a     = ah;
        mulh_shift = 1'b1;
        acc_load   = 1'b1;
        busy_o     = 1'b1;
        state_d    = mul_pkg::AHBH;
      end
      mul_pkg::AHBH: begin
        // Final term, hold here until writeback has room
        mulh_a = ah;
        mulh_b = bh;
        if (ex_ready_i) begin
          acc_clear = 1'b1;
          state_d   = mul_pkg::ALBL;
        end
      end
      default: state_d = mul_pkg::ALBL;
    endcase
  end

  //////////////////////////////
  // Shared multiplier
  //////////////////////////////
  // Full words for MUL, sign-extended halves otherwise
  assign op_a = is_m32 ? op_a_i : {{15{mulh_a[16]}}, mulh_a};
  assign op_b = is_m32 ? op_b_i : {{15{mulh_b[16]}}, mulh_b};

  assign int_result = $signed(op_a) * $signed(op_b);

  // Accumulate, then drop 16 bits after the low and middle terms
  assign acc_ext     = $signed({carry_q, acc_q});
  assign mulh_sum    = int_result + acc_ext;
  assign mulh_result = mulh_shift ? (mulh_sum >>> 16) : mulh_sum;

  assign product_o = is_m32 ? int_result[31:0] : mulh_result[31:0];

  // MUL finishes at once, the high word in AHBH
  assign done_o = (state_q == mul_pkg::AHBH) ||
                  ((state_q == mul_pkg::ALBL) && req_i.en && is_m32);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mul_pkg::ALBL;
      carry_q <= 1'b0;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      carry_q <= mulh_save && mulh_result[32];
      // Cleared on exit so the next sequence starts from zero
      if (acc_clear) begin
        acc_q <= '0;
      end else if (acc_load) begin
        acc_q <= mulh_result[31:0];
      end
    end
  end

endmodule

// File: source/mul_writeback.sv
// One-entry result register between the multiplier and the register file write port
`timescale 1ns/10ps

module mul_writeback (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 done_i,
  input  mul_pkg::word_t       product_i,
  input  instr_pkg::reg_addr_t rd_i,
  input  logic                 wb_ready_i,
  output logic                 ex_ready_o,
  output logic                 wb_valid_o,
  output mul_pkg::wb_data_t    wb_o
);

  // Entry state
  logic              valid_q;
  logic              load;
  mul_pkg::wb_data_t entry_q;

  // Room when empty or being drained this cycle
  assign ex_ready_o = !valid_q || wb_ready_i;
  assign load       = done_i && ex_ready_o;

  //////////////////////////////
  // Valid flag
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (wb_ready_i) begin
      // Taken with nothing new behind it
      valid_q <= 1'b0;
    end
  end

  // Payload holds while the consumer stalls
  always_ff @(posedge clk) begin
    if (load) begin
      entry_q.rd   <= rd_i;
      entry_q.data <= product_i;
    end
  end

  assign wb_valid_o = valid_q;
  assign wb_o       = entry_q;

endmodule

// File: source/mul_subsystem.sv
// Multiply subsystem top level joining decoder, subword multiplier and writeback register
`timescale 1ns/10ps

module mul_subsystem (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_i,
  input  instr_pkg::instr_t instr_i,
  input  mul_pkg::word_t    rs1_i,
  input  mul_pkg::word_t    rs2_i,
  input  logic              wb_ready_i,
  output logic              busy_o,
  output logic              illegal_o,
  output logic              wb_valid_o,
  output mul_pkg::wb_data_t wb_o
);

  // Internal links
  instr_pkg::mul_req_t req;
  mul_pkg::word_t      product;
  logic                done;
  logic                ex_ready;

  // Decode, raises illegal_o for anything else
  mul_decoder mul_decoder_i (
    .valid_i   (valid_i),
    .instr_i   (instr_i),
    .req_o     (req),
    .illegal_o (illegal_o)
  );

  // Stalls the issuer through the high-word steps
  mul_unit mul_unit_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .op_a_i     (rs1_i),
    .op_b_i     (rs2_i),
    .ex_ready_i (ex_ready),
    .product_o  (product),
    .done_o     (done),
    .busy_o     (busy_o)
  );

  mul_writeback mul_writeback_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .done_i     (done),
    .product_i  (product),
    .rd_i       (req.rd),
    .wb_ready_i (wb_ready_i),
    .ex_ready_o (ex_ready),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o)
  );

endmodule

// File: test/mul_subsystem_assertions.sv
// Concurrent protocol checks, bound into the multiply subsystem top level during simulation
`timescale 1ns/10ps

module mul_subsystem_assertions (
  input logic              clk,
  input logic              rst_n,
  input logic              busy_o,
  input logic              illegal_o,
  input logic              wb_valid_o,
  input logic              wb_ready_i,
  input mul_pkg::wb_data_t wb_o
);

  // Stalled entry must not move
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> $stable(wb_o))
    else $error("wb_o changed while the writeback side was stalled");

  // A non-multiply never starts the sequence
  assert property (@(posedge clk) disable iff (!rst_n) !(illegal_o && busy_o))
    else $error("illegal_o and busy_o high together");

  // Register comes out of reset empty
  assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid_o)
    else $error("wb_valid_o high in the first cycle after reset");

endmodule

bind mul_subsystem mul_subsystem_assertions mul_subsystem_assertions_i (.*);

// File: test/tb_mul_subsystem.sv
// Directed testbench for the multiply subsystem, compiled from the project file list with this top
`timescale 1ns/10ps

module tb_mul_subsystem;

  // 4x4 corner pairs plus random pairs, shared by every operator
  localparam int N_CORNER   = 4;
  localparam int N_PAIRS    = N_CORNER * N_CORNER + 20;
  // Four operators over all pairs, two back-pressure and two non-multiply instructions
  localparam int N_INSTR    = 4 * N_PAIRS + 4;
  localparam int MAX_CYCLES = 40 * N_INSTR + 100;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              valid_i;
  instr_pkg::instr_t instr_i;
  mul_pkg::word_t    rs1_i;
  mul_pkg::word_t    rs2_i;
  logic              wb_ready_i;
  logic              busy_o;
  logic              illegal_o;
  logic              wb_valid_o;
  mul_pkg::wb_data_t wb_o;

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  integer      seed        = 7;
  logic [31:0] pair_a [N_PAIRS];
  logic [31:0] pair_b [N_PAIRS];

  mul_subsystem mul_subsystem_i (.*);

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////
  // Timeout
  //////////////////////////////
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished the test sequence", cycle_count);
      error_count++;
      $display("Summary: %0d checks, %0d errors", check_count, error_count);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  // Expected result from the 64-bit product of the extended operands
  function automatic logic [31:0] ref_result(input logic [2:0] funct3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (funct3 == instr_pkg::FUNCT3_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
    eb = (funct3 == instr_pkg::FUNCT3_MULH || funct3 == instr_pkg::FUNCT3_MUL) ?
         {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return (funct3 == instr_pkg::FUNCT3_MUL) ? p[31:0] : p[63:32];
  endfunction

  // R-type word, register source fields do not matter here
  function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd);
    return {funct7, 5'd2, 5'd1, funct3, rd, instr_pkg::OPCODE_OP};
  endfunction

  //////////////////////////////
  // Drive and wait helpers
  //////////////////////////////
  task automatic present(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
    @(posedge clk);
    #10;
    valid_i = 1'b1;
    instr_i = instr;
    rs1_i   = a;
    rs2_i   = b;
  endtask

  // Counts busy cycles, returns at the first sample with busy_o low
  task automatic count_busy(output int busy_cycles);
    busy_cycles = 0;
    forever begin
      @(negedge clk);
      check_value(illegal_o, 1'b0, "illegal_o on a multiply");
      if (!busy_o) break;
      busy_cycles++;
    end
  endtask

  // Accepted once the writeback side has room
  task automatic wait_accept(output int busy_cycles);
    count_busy(busy_cycles);
    while (wb_valid_o && !wb_ready_i) @(negedge clk);
  endtask

  task automatic release_inputs();
    @(posedge clk);
    #10;
    valid_i = 1'b0;
  endtask

  task automatic expect_result(input logic [4:0] rd, input logic [31:0] data, input string msg);
    do @(negedge clk); while (!wb_valid_o);
    check_value(wb_o.rd, rd, {msg, " rd"});
    check_value(wb_o.data, data, {msg, " data"});
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_reset();
    @(negedge clk);
    check_value(wb_valid_o, 1'b0, "wb_valid_o after reset");
    check_value(busy_o, 1'b0, "busy_o after reset");
    check_value(illegal_o, 1'b0, "illegal_o after reset");
  endtask

  task automatic build_operands();
    logic [31:0] corner [N_CORNER];
    corner = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    for (int i = 0; i < N_CORNER * N_CORNER; i++) begin
      pair_a[i] = corner[i / N_CORNER];
      pair_b[i] = corner[i % N_CORNER];
    end
    for (int i = N_CORNER * N_CORNER; i < N_PAIRS; i++) begin
      pair_a[i] = $random(seed);
      pair_b[i] = $random(seed);
    end
  endtask

  // One operator over the whole operand set
  task automatic run_pairs(input logic [2:0] funct3);
    int          busy_cycles;
    logic [4:0]  rd;
    string       msg;
    for (int i = 0; i < N_PAIRS; i++) begin
      rd  = 5'((i % 31) + 1);
      msg = $sformatf("funct3 %0d a=%h b=%h", funct3, pair_a[i], pair_b[i]);
      present(encode_r(instr_pkg::FUNCT7_MULDIV, funct3, rd), pair_a[i], pair_b[i]);
      wait_accept(busy_cycles);
      release_inputs();
      // High word spends ALBL, ALBH and AHBL busy
      check_value(busy_cycles, (funct3 == instr_pkg::FUNCT3_MUL) ? 0 : 3, {msg, " busy cycles"});
      expect_result(rd, ref_result(funct3, pair_a[i], pair_b[i]), msg);
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] exp1;
    logic [31:0] exp2;
    int          busy_cycles;
    exp1 = ref_result(instr_pkg::FUNCT3_MUL, 32'h1234_5678, 32'h9abc_def0);
    exp2 = ref_result(instr_pkg::FUNCT3_MULH, 32'hfedc_ba98, 32'h7654_3210);
    @(posedge clk);
    #10;
    wb_ready_i = 1'b0;
    present(encode_r(instr_pkg::FUNCT7_MULDIV, instr_pkg::FUNCT3_MUL, 5'd3),
            32'h1234_5678, 32'h9abc_def0);
    wait_accept(busy_cycles);
    release_inputs();
    expect_result(5'd3, exp1, "stalled MUL");
    present(encode_r(instr_pkg::FUNCT7_MULDIV, instr_pkg::FUNCT3_MULH, 5'd4),
            32'hfedc_ba98, 32'h7654_3210);
    count_busy(busy_cycles);
    check_value(busy_cycles, 3, "stalled MULH busy cycles");
    // Second result parked in AHBH, first still on the port
    repeat (4) begin
      check_value(busy_o, 1'b0, "busy_o while stalled");
      check_value(mul_subsystem_i.done, 1'b1, "done while stalled");
      check_value(wb_valid_o, 1'b1, "wb_valid_o while stalled");
      check_value(wb_o.data, exp1, "first result held");
      @(negedge clk);
    end
    @(posedge clk);
    #10;
    wb_ready_i = 1'b1;
    @(negedge clk);
    check_value(wb_o.rd, 5'd3, "first result taken rd");
    check_value(wb_o.data, exp1, "first result taken data");
    release_inputs();
    expect_result(5'd4, exp2, "stalled MULH");
  endtask

  task automatic test_illegal(input logic [31:0] instr, input string name);
    present(instr, 32'h0000_0005, 32'h0000_0007);
    repeat (3) begin
      @(negedge clk);
      check_value(illegal_o, 1'b1, {name, " illegal_o"});
      check_value(busy_o, 1'b0, {name, " busy_o"});
      check_value(wb_valid_o, 1'b0, {name, " wb_valid_o"});
    end
    release_inputs();
    @(negedge clk);
    check_value(illegal_o, 1'b0, {name, " illegal_o released"});
    check_value(wb_valid_o, 1'b0, {name, " no result"});
  endtask

  initial begin
    rst_n      = 1'b0;
    valid_i    = 1'b0;
    instr_i    = '0;
    rs1_i      = '0;
    rs2_i      = '0;
    wb_ready_i = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_reset();
    build_operands();
    run_pairs(instr_pkg::FUNCT3_MUL);
    run_pairs(instr_pkg::FUNCT3_MULH);
    run_pairs(instr_pkg::FUNCT3_MULHSU);
    run_pairs(instr_pkg::FUNCT3_MULHU);
    test_backpressure();
    // DIV, then ADD
    test_illegal(encode_r(instr_pkg::FUNCT7_MULDIV, 3'b100, 5'd5), "DIV");
    test_illegal(encode_r(7'b0000000, 3'b000, 5'd6), "ADD");
    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
source/mul_pkg.sv
source/instr_pkg.sv
source/mul_decoder.sv
source/mul_unit.sv
source/mul_writeback.sv
source/mul_subsystem.sv
test/mul_subsystem_assertions.sv
test/tb_mul_subsystem.sv

// File: Bender.yml
package:
  name: mul_subsystem

sources:
  # Packages first, mul_pkg is used by instr_pkg
  - files:
      - source/mul_pkg.sv
      - source/instr_pkg.sv
      - source/mul_decoder.sv
      - source/mul_unit.sv
      - source/mul_writeback.sv
      - source/mul_subsystem.sv
  - target: test
    files:
      - test/mul_subsystem_assertions.sv
      - test/tb_mul_subsystem.sv
